// ==== rtl/cb_pkg.sv ====
// Core bus definitions
// Split address/data channel types, size and response codes, data memory geometry
package cb_pkg;

  typedef logic [31:0] cb_addr_t;
  typedef logic [31:0] cb_data_t;
  typedef logic [3:0]  cb_strb_t;

  typedef enum logic [1:0] {
    CB_BYTE      = 2'b00,
    CB_HALF_WORD = 2'b01,
    CB_WORD      = 2'b10
  } cb_size_t;

  typedef enum logic [1:0] {
    CB_OKAY   = 2'b00,
    CB_SLVERR = 2'b10
  } cb_resp_t;

  // Master to slave
  typedef struct packed {
    cb_addr_t wr_addr;
    cb_size_t wr_size;
    logic     wr_addr_valid;
    cb_data_t wr_data;
    cb_strb_t wr_strobe;
    logic     wr_data_valid;
    logic     wr_resp_ready;
    cb_addr_t rd_addr;
    cb_size_t rd_size;
    logic     rd_addr_valid;
    logic     rd_ready;
  } s_cb_mosi_t;

  // Slave to master
  typedef struct packed {
    logic     wr_addr_ready;
    logic     wr_data_ready;
    cb_resp_t wr_resp_error;
    logic     rd_addr_ready;
    cb_data_t rd_data;
    cb_resp_t rd_resp;
    logic     rd_valid;
  } s_cb_miso_t;

  // On-chip data memory
  localparam int MEM_WORDS   = 256;
  localparam int MEM_AW      = 8;
  localparam int WAIT_CYCLES = 2;

endpackage

// ==== rtl/lsu_pkg.sv ====
// Load/store unit definitions
// Decoded memory operation, access widths and trap information
package lsu_pkg;

  typedef enum logic [1:0] {
    NO_LSU    = 2'b00,
    LSU_LOAD  = 2'b01,
    LSU_STORE = 2'b10
  } lsu_op_typ_t;

  // Access widths, U variants zero-extend on load
  typedef enum logic [2:0] {
    RV_LSU_B  = 3'b000,
    RV_LSU_H  = 3'b001,
    RV_LSU_W  = 3'b010,
    RV_LSU_BU = 3'b100,
    RV_LSU_HU = 3'b101
  } lsu_w_t;

  typedef struct packed {
    lsu_op_typ_t op_typ;
    lsu_w_t      width;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [4:0]  rd;
  } s_lsu_op_t;

  typedef logic [31:0] rdata_t;

  typedef struct packed {
    logic        active;
    logic [3:0]  cause;
    logic [31:0] mtval;
  } s_trap_info_t;

  // mcause codes for bus access faults
  localparam logic [3:0] LOAD_ACCESS_FAULT  = 4'd5;
  localparam logic [3:0] STORE_ACCESS_FAULT = 4'd7;

endpackage

// ==== rtl/lsu.sv ====
// Load/store unit
// Issues one load or store at a time on the core bus and stalls execute while busy
`timescale 1ns/1ps
module lsu
  import cb_pkg::*;
  import lsu_pkg::*;
(
  input                clk,
  input                rst_i,
  // Execute stage
  input  s_lsu_op_t    lsu_i,
  output logic         lsu_bp_o,
  // Write-back
  output logic         wb_valid_o,
  output s_lsu_op_t    wb_lsu_o,
  output rdata_t       lsu_data_o,
  // Core data bus
  output s_cb_mosi_t   data_cb_mosi_o,
  input  s_cb_miso_t   data_cb_miso_i,
  // Access fault
  output logic         txn_error_o,
  output s_trap_info_t trap_info_o
);

  s_lsu_op_t lsu_ff;
  s_lsu_op_t next_lsu;
  logic      req_ff;
  logic      next_req;
  logic      new_txn;
  logic      rd_txn;
  logic      wr_txn_dp;
  logic      data_done;
  logic      bp_addr;
  logic      bp_data;
  logic      addr_ready;

  function automatic cb_size_t size_txn(lsu_w_t width);
    cb_size_t sz;
    case (width)
      RV_LSU_B, RV_LSU_BU: sz = CB_BYTE;
      RV_LSU_H, RV_LSU_HU: sz = CB_HALF_WORD;
      default:             sz = CB_WORD;
    endcase
    return sz;
  endfunction

  function automatic cb_strb_t mask_strb(lsu_w_t width);
    cb_strb_t mask;
    case (width)
      RV_LSU_B, RV_LSU_BU: mask = 4'b0001;
      RV_LSU_H, RV_LSU_HU: mask = 4'b0011;
      default:             mask = 4'b1111;
    endcase
    return mask;
  endfunction

  always_comb begin
    new_txn    = (lsu_i.op_typ != NO_LSU);
    rd_txn     = (lsu_i.op_typ == LSU_LOAD);
    wr_txn_dp  = (lsu_ff.op_typ == LSU_STORE);
    addr_ready = rd_txn ? data_cb_miso_i.rd_addr_ready : data_cb_miso_i.wr_addr_ready;

    // Data phase finishes on the slave's single data cycle
    data_done = req_ff && (wr_txn_dp ? data_cb_miso_i.wr_data_ready :
                                       data_cb_miso_i.rd_valid);
    bp_data   = req_ff && !data_done;
    bp_addr   = new_txn && !addr_ready;
    lsu_bp_o  = bp_addr || bp_data;

    data_cb_mosi_o               = s_cb_mosi_t'('0);
    data_cb_mosi_o.rd_ready      = 1'b1;
    data_cb_mosi_o.wr_resp_ready = 1'b1;

    // Address phase, overlaps the data phase of the previous operation
    if (new_txn && !bp_data) begin
      if (rd_txn) begin
        data_cb_mosi_o.rd_addr       = lsu_i.addr;
        data_cb_mosi_o.rd_size       = size_txn(lsu_i.width);
        data_cb_mosi_o.rd_addr_valid = 1'b1;
      end else begin
        data_cb_mosi_o.wr_addr       = lsu_i.addr;
        data_cb_mosi_o.wr_size       = size_txn(lsu_i.width);
        data_cb_mosi_o.wr_addr_valid = 1'b1;
      end
    end

    // Store data goes out on the lane picked by the low address bits
    if (req_ff && wr_txn_dp) begin
      data_cb_mosi_o.wr_data       = lsu_ff.wdata << {lsu_ff.addr[1:0], 3'b000};
      data_cb_mosi_o.wr_strobe     = mask_strb(lsu_ff.width) << lsu_ff.addr[1:0];
      data_cb_mosi_o.wr_data_valid = 1'b1;
    end

    next_req = req_ff;
    next_lsu = lsu_ff;
    if (!lsu_bp_o) begin
      next_req = new_txn;
      next_lsu = lsu_i;
    end else if (data_done) begin
      // Finished but the next address is still waiting
      next_req = 1'b0;
    end

    wb_valid_o  = data_done;
    wb_lsu_o    = lsu_ff;
    lsu_data_o  = data_cb_miso_i.rd_data;
    txn_error_o = data_done && (wr_txn_dp ? (data_cb_miso_i.wr_resp_error != CB_OKAY) :
                                            (data_cb_miso_i.rd_resp != CB_OKAY));

    trap_info_o = s_trap_info_t'('0);
    if (txn_error_o) begin
      trap_info_o.active = 1'b1;
      trap_info_o.cause  = wr_txn_dp ? STORE_ACCESS_FAULT : LOAD_ACCESS_FAULT;
      trap_info_o.mtval  = lsu_ff.addr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      lsu_ff <= s_lsu_op_t'('0);
      req_ff <= 1'b0;
    end else begin
      lsu_ff <= next_lsu;
      req_ff <= next_req;
    end
  end

endmodule

// ==== rtl/load_align.sv ====
// Load data aligner
// Picks the addressed byte or halfword of the bus word and extends it
`timescale 1ns/1ps
module load_align
  import cb_pkg::*;
  import lsu_pkg::*;
(
  input  s_lsu_op_t wb_lsu_i,
  input  rdata_t    lsu_data_i,
  output rdata_t    wb_data_o
);

  cb_size_t    sz;
  logic        zext;
  logic [7:0]  byte_v;
  logic [15:0] half_v;

  always_comb begin
    byte_v = lsu_data_i[{wb_lsu_i.addr[1:0], 3'b000} +: 8];
    half_v = wb_lsu_i.addr[1] ? lsu_data_i[31:16] : lsu_data_i[15:0];

    case (wb_lsu_i.width)
      RV_LSU_B:  begin sz = CB_BYTE;      zext = 1'b0; end
      RV_LSU_BU: begin sz = CB_BYTE;      zext = 1'b1; end
      RV_LSU_H:  begin sz = CB_HALF_WORD; zext = 1'b0; end
      RV_LSU_HU: begin sz = CB_HALF_WORD; zext = 1'b1; end
      default:   begin sz = CB_WORD;      zext = 1'b0; end
    endcase

    wb_data_o = '0;
    // Stores write nothing back
    if (wb_lsu_i.op_typ == LSU_LOAD) begin
      case (sz)
        CB_BYTE:      wb_data_o = {{24{byte_v[7] & ~zext}}, byte_v};
        CB_HALF_WORD: wb_data_o = {{16{half_v[15] & ~zext}}, half_v};
        default:      wb_data_o = lsu_data_i;
      endcase
    end
  end

endmodule

// ==== rtl/cb_slave_fsm.sv ====
// Core bus slave controller
// Accepts one address, waits a fixed number of cycles, then runs one data cycle
`timescale 1ns/1ps
module cb_slave_fsm
  import cb_pkg::*;
(
  input              clk,
  input              rst_i,
  input  s_cb_mosi_t cb_mosi_i,
  output s_cb_miso_t cb_miso_o,
  // Wait-state timer
  output logic       tmr_start_o,
  input  logic       tmr_done_i,
  // Memory side
  output logic       mem_we_o,
  output cb_addr_t   mem_addr_o,
  output cb_size_t   mem_size_o,
  output cb_data_t   mem_wdata_o,
  output cb_strb_t   mem_strb_o,
  input  cb_data_t   mem_rdata_i,
  input  logic       mem_err_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_DATA
  } state_t;

  state_t   state_ff;
  state_t   next_state;
  cb_addr_t addr_ff;
  cb_size_t size_ff;
  logic     wr_ff;
  logic     accept;
  logic     accept_wr;

  always_comb begin
    // Writes win when both channels present an address
    accept_wr   = cb_mosi_i.wr_addr_valid;
    accept      = (state_ff == ST_IDLE) &&
                  (cb_mosi_i.wr_addr_valid || cb_mosi_i.rd_addr_valid);
    tmr_start_o = accept;

    cb_miso_o               = s_cb_miso_t'('0);
    cb_miso_o.wr_addr_ready = (state_ff == ST_IDLE);
    cb_miso_o.rd_addr_ready = (state_ff == ST_IDLE);

    mem_addr_o  = addr_ff;
    mem_size_o  = size_ff;
    mem_wdata_o = cb_mosi_i.wr_data;
    mem_strb_o  = cb_mosi_i.wr_strobe;
    mem_we_o    = 1'b0;

    next_state = state_ff;
    case (state_ff)
      ST_IDLE: if (accept) next_state = ST_WAIT;
      ST_WAIT: if (tmr_done_i) next_state = ST_DATA;
      ST_DATA: begin
        if (wr_ff) begin
          cb_miso_o.wr_data_ready = 1'b1;
          cb_miso_o.wr_resp_error = mem_err_i ? CB_SLVERR : CB_OKAY;
          mem_we_o                = cb_mosi_i.wr_data_valid && !mem_err_i;
        end else begin
          cb_miso_o.rd_valid = 1'b1;
          cb_miso_o.rd_data  = mem_err_i ? '0 : mem_rdata_i;
          cb_miso_o.rd_resp  = mem_err_i ? CB_SLVERR : CB_OKAY;
        end
        next_state = ST_IDLE;
      end
      default: next_state = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_ff <= ST_IDLE;
      wr_ff    <= 1'b0;
    end else begin
      state_ff <= next_state;
      if (accept) wr_ff <= accept_wr;
    end
  end

  // Address and size of the accepted request
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_ff <= accept_wr ? cb_mosi_i.wr_addr : cb_mosi_i.rd_addr;
      size_ff <= accept_wr ? cb_mosi_i.wr_size : cb_mosi_i.rd_size;
    end
  end

endmodule

// ==== rtl/wait_timer.sv ====
// Wait-state down counter for the memory slave
`timescale 1ns/1ps
module wait_timer
  import cb_pkg::*;
(
  input        clk,
  input        rst_i,
  input  logic start_i,
  output logic done_o
);

  localparam int CW = $clog2(WAIT_CYCLES + 1);

  logic [CW-1:0] cnt_ff;

  // Expires on the last wait cycle
  assign done_o = (cnt_ff == CW'(1));

  always_ff @(posedge clk) begin
    if (rst_i) begin
      cnt_ff <= '0;
    end else if (start_i) begin
      cnt_ff <= CW'(WAIT_CYCLES);
    end else if (cnt_ff != '0) begin
      cnt_ff <= cnt_ff - CW'(1);
    end
  end

endmodule

// ==== rtl/cb_sram.sv ====
// On-chip data memory
// Word array with byte strobes plus range and alignment checks
`timescale 1ns/1ps
module cb_sram
  import cb_pkg::*;
(
  input              clk,
  input  logic       we_i,
  input  cb_addr_t   addr_i,
  input  cb_size_t   size_i,
  input  cb_data_t   wdata_i,
  input  cb_strb_t   strb_i,
  output cb_data_t   rdata_o,
  output logic       err_o
);

  cb_data_t          mem [MEM_WORDS];
  logic [MEM_AW-1:0] idx;
  logic              out_of_range;
  logic              misaligned;

  always_comb begin
    idx          = addr_i[MEM_AW+1:2];
    out_of_range = (addr_i[31:2] >= 30'(MEM_WORDS));
    misaligned   = ((size_i == CB_HALF_WORD) && addr_i[0]) ||
                   ((size_i == CB_WORD) && (addr_i[1:0] != 2'b00));
    err_o        = out_of_range || misaligned;
  end

  // Asynchronous read
  assign rdata_o = mem[idx];

  always_ff @(posedge clk) begin
    if (we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (strb_i[b]) begin
          mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

endmodule

// ==== rtl/lsu_mem_top.sv ====
// Memory-access subsystem
// Load/store unit and load aligner in front of a wait-stated data memory slave
`timescale 1ns/1ps
module lsu_mem_top
  import cb_pkg::*;
  import lsu_pkg::*;
(
  input                clk,
  input                rst_i,
  input  s_lsu_op_t    lsu_i,
  output logic         lsu_bp_o,
  output logic         wb_valid_o,
  output s_lsu_op_t    wb_lsu_o,
  output rdata_t       wb_data_o,
  output logic         txn_error_o,
  output s_trap_info_t trap_info_o
);

  s_cb_mosi_t data_cb_mosi;
  s_cb_miso_t data_cb_miso;
  rdata_t     lsu_data;
  logic       tmr_start;
  logic       tmr_done;
  logic       mem_we;
  cb_addr_t   mem_addr;
  cb_size_t   mem_size;
  cb_data_t   mem_wdata;
  cb_strb_t   mem_strb;
  cb_data_t   mem_rdata;
  logic       mem_err;

  lsu u_lsu (
    .clk            (clk),
    .rst_i          (rst_i),
    .lsu_i          (lsu_i),
    .lsu_bp_o       (lsu_bp_o),
    .wb_valid_o     (wb_valid_o),
    .wb_lsu_o       (wb_lsu_o),
    .lsu_data_o     (lsu_data),
    .data_cb_mosi_o (data_cb_mosi),
    .data_cb_miso_i (data_cb_miso),
    .txn_error_o    (txn_error_o),
    .trap_info_o    (trap_info_o)
  );

  // Write-back op drives both the port and the aligner
  load_align u_load_align (
    .wb_lsu_i   (wb_lsu_o),
    .lsu_data_i (lsu_data),
    .wb_data_o  (wb_data_o)
  );

  cb_slave_fsm u_cb_slave_fsm (
    .clk         (clk),
    .rst_i       (rst_i),
    .cb_mosi_i   (data_cb_mosi),
    .cb_miso_o   (data_cb_miso),
    .tmr_start_o (tmr_start),
    .tmr_done_i  (tmr_done),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_size_o  (mem_size),
    .mem_wdata_o (mem_wdata),
    .mem_strb_o  (mem_strb),
    .mem_rdata_i (mem_rdata),
    .mem_err_i   (mem_err)
  );

  wait_timer u_wait_timer (
    .clk     (clk),
    .rst_i   (rst_i),
    .start_i (tmr_start),
    .done_o  (tmr_done)
  );

  cb_sram u_cb_sram (
    .clk     (clk),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .size_i  (mem_size),
    .wdata_i (mem_wdata),
    .strb_i  (mem_strb),
    .rdata_o (mem_rdata),
    .err_o   (mem_err)
  );

endmodule

// ==== verification/tb_lsu_mem.sv ====
// Testbench for the memory-access subsystem
// Table of loads and stores checked against a reference memory model
`timescale 1ns/1ps
module tb_lsu_mem
  import cb_pkg::*;
  import lsu_pkg::*;
();

  localparam int MAX_OPS    = 64;
  localparam int CLK_HALF   = 10;
  localparam int RST_CYCLES = 10;
  localparam int N_RAND     = 8;

  typedef struct {
    string       name;
    lsu_op_typ_t op;
    lsu_w_t      width;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_data;
    logic        exp_err;
  } entry_t;

  logic         clk;
  logic         rst_i;
  s_lsu_op_t    lsu_i;
  logic         lsu_bp_o;
  logic         wb_valid_o;
  s_lsu_op_t    wb_lsu_o;
  rdata_t       wb_data_o;
  logic         txn_error_o;
  s_trap_info_t trap_info_o;

  entry_t      tbl [MAX_OPS];
  logic [31:0] ref_mem [MEM_WORDS];
  int          n_ops;
  int          cyc;
  int          done_cnt;
  int          last_done;
  int          err_cnt;
  int          acc_q [$];
  logic        built;

  lsu_mem_top u_dut (
    .clk         (clk),
    .rst_i       (rst_i),
    .lsu_i       (lsu_i),
    .lsu_bp_o    (lsu_bp_o),
    .wb_valid_o  (wb_valid_o),
    .wb_lsu_o    (wb_lsu_o),
    .wb_data_o   (wb_data_o),
    .txn_error_o (txn_error_o),
    .trap_info_o (trap_info_o)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // Out of range, odd halfword or unaligned word
  function automatic logic access_bad(logic [31:0] addr, lsu_w_t width);
    logic half;
    half = (width == RV_LSU_H) || (width == RV_LSU_HU);
    return ((addr >> 2) >= MEM_WORDS) || (half && addr[0]) ||
           ((width == RV_LSU_W) && (addr[1:0] != 2'b00));
  endfunction

  function automatic int width_bytes(lsu_w_t width);
    case (width)
      RV_LSU_B, RV_LSU_BU: return 1;
      RV_LSU_H, RV_LSU_HU: return 2;
      default:             return 4;
    endcase
  endfunction

  function automatic s_lsu_op_t to_op(entry_t e);
    s_lsu_op_t op;
    op        = '0;
    op.op_typ = e.op;
    op.width  = e.width;
    op.addr   = e.addr;
    op.wdata  = e.wdata;
    op.rd     = 5'd1;
    return op;
  endfunction

  // Appends one operation, expected result taken from the model
  task automatic add_op(string name, lsu_op_typ_t op, lsu_w_t width,
                        logic [31:0] addr, logic [31:0] wdata);
    entry_t      e;
    logic [31:0] word;
    int          lane;
    e.name     = name;
    e.op       = op;
    e.width    = width;
    e.addr     = addr;
    e.wdata    = wdata;
    e.exp_err  = access_bad(addr, width);
    e.exp_data = '0;
    word       = ref_mem[addr[MEM_AW+1:2]];
    lane       = addr[1:0];
    if (!e.exp_err && op == LSU_STORE) begin
      for (int b = 0; b < width_bytes(width); b++) begin
        word[8*(lane+b) +: 8] = wdata[8*b +: 8];
      end
      ref_mem[addr[MEM_AW+1:2]] = word;
    end else if (!e.exp_err) begin
      word = word >> (8 * lane);
      case (width)
        RV_LSU_B:  e.exp_data = {{24{word[7]}}, word[7:0]};
        RV_LSU_BU: e.exp_data = {24'h0, word[7:0]};
        RV_LSU_H:  e.exp_data = {{16{word[15]}}, word[15:0]};
        RV_LSU_HU: e.exp_data = {16'h0, word[15:0]};
        default:   e.exp_data = word;
      endcase
    end
    tbl[n_ops] = e;
    n_ops++;
  endtask

  task automatic build_table();
    logic [31:0] rnd_addr [N_RAND];
    add_op("sw_word", LSU_STORE, RV_LSU_W, 32'h10, 32'h1234_5678);
    add_op("lw_word", LSU_LOAD, RV_LSU_W, 32'h10, 32'h0);
    add_op("sw_lane_init", LSU_STORE, RV_LSU_W, 32'h20, 32'hAABB_CCDD);
    for (int l = 0; l < 4; l++) begin
      add_op($sformatf("sb_lane%0d", l), LSU_STORE, RV_LSU_B, 32'h20 + l, 32'h80 + l);
      add_op($sformatf("lw_after_sb%0d", l), LSU_LOAD, RV_LSU_W, 32'h20, 32'h0);
    end
    // Two negative bytes, one negative halfword
    add_op("sw_ext_init", LSU_STORE, RV_LSU_W, 32'h30, 32'h8FF0_700D);
    for (int l = 0; l < 4; l++) begin
      add_op($sformatf("lb_lane%0d", l), LSU_LOAD, RV_LSU_B, 32'h30 + l, 32'h0);
      add_op($sformatf("lbu_lane%0d", l), LSU_LOAD, RV_LSU_BU, 32'h30 + l, 32'h0);
    end
    for (int l = 0; l < 4; l += 2) begin
      add_op($sformatf("lh_off%0d", l), LSU_LOAD, RV_LSU_H, 32'h30 + l, 32'h0);
      add_op($sformatf("lhu_off%0d", l), LSU_LOAD, RV_LSU_HU, 32'h30 + l, 32'h0);
    end
    // 0x400 aliases word 0 in the index bits
    add_op("sw_alias_init", LSU_STORE, RV_LSU_W, 32'h0, 32'hCAFE_0001);
    add_op("lw_out_of_range", LSU_LOAD, RV_LSU_W, 32'h400, 32'h0);
    add_op("sw_out_of_range", LSU_STORE, RV_LSU_W, 32'h400, 32'h5555_5555);
    add_op("lw_alias_check", LSU_LOAD, RV_LSU_W, 32'h0, 32'h0);
    add_op("lh_odd", LSU_LOAD, RV_LSU_H, 32'h31, 32'h0);
    add_op("sh_odd", LSU_STORE, RV_LSU_H, 32'h31, 32'h0000_FFFF);
    add_op("lw_misaligned", LSU_LOAD, RV_LSU_W, 32'h32, 32'h0);
    add_op("sw_misaligned", LSU_STORE, RV_LSU_W, 32'h32, 32'hDEAD_BEEF);
    add_op("lw_fault_check", LSU_LOAD, RV_LSU_W, 32'h30, 32'h0);
    for (int r = 0; r < N_RAND; r++) begin
      rnd_addr[r] = ($urandom() % MEM_WORDS) << 2;
      add_op($sformatf("sw_rand%0d", r), LSU_STORE, RV_LSU_W, rnd_addr[r], $urandom());
    end
    for (int r = 0; r < N_RAND; r++) begin
      add_op($sformatf("lw_rand%0d", r), LSU_LOAD, RV_LSU_W, rnd_addr[r], 32'h0);
    end
  endtask

  task automatic report_mismatch(string name, string what, logic [31:0] exp,
                                 logic [31:0] act);
    $display("CHECK FAILED %s %s expected %h actual %h", name, what, exp, act);
    err_cnt++;
  endtask

  task automatic check_completion();
    entry_t    e;
    int        acc;
    s_lsu_op_t exp_op;
    if (done_cnt >= n_ops || acc_q.size() == 0) begin
      $display("Write-back seen at cycle %0d with no operation outstanding", cyc);
      err_cnt++;
      return;
    end
    e      = tbl[done_cnt];
    acc    = acc_q.pop_front();
    exp_op = to_op(e);
    if (wb_lsu_o !== exp_op) begin
      $display("CHECK FAILED %s wb_lsu_o expected %h actual %h", e.name, exp_op, wb_lsu_o);
      err_cnt++;
    end
    if (e.op == LSU_LOAD && !e.exp_err && wb_data_o !== e.exp_data) begin
      report_mismatch(e.name, "wb_data_o", e.exp_data, wb_data_o);
    end
    if (txn_error_o !== e.exp_err) begin
      report_mismatch(e.name, "txn_error_o", 32'(e.exp_err), 32'(txn_error_o));
    end
    if (trap_info_o.active !== e.exp_err) begin
      report_mismatch(e.name, "trap active", 32'(e.exp_err), 32'(trap_info_o.active));
    end
    if (e.exp_err) begin
      if (trap_info_o.cause !== (e.op == LSU_STORE ? STORE_ACCESS_FAULT : LOAD_ACCESS_FAULT)) begin
        report_mismatch(e.name, "trap cause",
                        32'(e.op == LSU_STORE ? STORE_ACCESS_FAULT : LOAD_ACCESS_FAULT),
                        32'(trap_info_o.cause));
      end
      if (trap_info_o.mtval !== e.addr) begin
        report_mismatch(e.name, "mtval", e.addr, trap_info_o.mtval);
      end
    end
    // Three cycles from acceptance, four between back-to-back completions
    if (cyc - acc != 3) begin
      report_mismatch(e.name, "accept to write-back cycles", 32'd3, 32'(cyc - acc));
    end
    if (done_cnt > 0 && cyc - last_done != 4) begin
      report_mismatch(e.name, "write-back spacing", 32'd4, 32'(cyc - last_done));
    end
    last_done = cyc;
    done_cnt++;
  endtask

  // Sample on the falling edge, away from the driving edge
  always @(negedge clk) begin
    if (!rst_i) begin
      if (lsu_i.op_typ != NO_LSU && !lsu_bp_o) begin
        acc_q.push_back(cyc);
      end
      if (wb_valid_o) begin
        check_completion();
      end
    end
    cyc = cyc + 1;
  end

  initial begin
    rst_i     = 1'b1;
    lsu_i     = '0;
    cyc       = 0;
    done_cnt  = 0;
    last_done = 0;
    err_cnt   = 0;
    n_ops     = 0;
    built     = 1'b0;
    void'($urandom(32'h9961));
    build_table();
    built = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst_i <= 1'b0;
    @(negedge clk);
    if (lsu_bp_o !== 1'b0 || wb_valid_o !== 1'b0) begin
      $display("Back-pressure or write-back active after reset with no operation");
      err_cnt++;
    end
    for (int i = 0; i < n_ops; i++) begin
      @(posedge clk);
      lsu_i <= to_op(tbl[i]);
      do @(negedge clk); while (lsu_bp_o !== 1'b0);
    end
    @(posedge clk);
    lsu_i <= '0;
    wait (done_cnt == n_ops);
    @(negedge clk);
    $display("Summary: %0d of %0d operations completed, %0d errors", done_cnt, n_ops, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    wait (built);
    repeat (RST_CYCLES + 6 * n_ops) @(posedge clk);
    $display("Run timed out before all operations wrote back");
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== flist.f ====
rtl/cb_pkg.sv
rtl/lsu_pkg.sv
rtl/lsu.sv
rtl/load_align.sv
rtl/cb_slave_fsm.sv
rtl/wait_timer.sv
rtl/cb_sram.sv
rtl/lsu_mem_top.sv
verification/tb_lsu_mem.sv
